// ==== source/pcomp_settings.svh ====
//**************************************************
// address map, RAM depth and GPIO register offsets
//**************************************************

`ifndef PCOMP_SETTINGS_SVH
`define PCOMP_SETTINGS_SVH

`define PCOMP_ADDR_W 32

// word RAM, 4096 words
`define PCOMP_RAM_DEPTH 12
`define PCOMP_RAM_BASE 32'h0000_0000
`define PCOMP_RAM_MASK 32'h0000_3fff

// GPIO window, 16 bytes
`define PCOMP_GPIO_BASE 32'h9000_0000
`define PCOMP_GPIO_MASK 32'h0000_000f

// GPIO byte offsets
`define PCOMP_GPIO_LED 32'h0
`define PCOMP_GPIO_BTN 32'h4
`define PCOMP_GPIO_IRQ 32'h8

`endif

// ==== source/pcomp_pkg.sv ====
//**************************************************
// shared types: bus address, data word, AXI
// response code and the bridge FSM states
//**************************************************

`default_nettype none

`include "pcomp_settings.svh"

package pcomp_pkg;

    typedef logic [`PCOMP_ADDR_W-1:0] addr_t;

    typedef logic [31:0] word_t;

    // AXI response code
    typedef logic [1:0] resp_t;

    typedef enum logic [2:0] {
        idle,
        access,
        wait_ready,
        write_resp,
        read_resp
    } bridge_state_t;

endpackage

`default_nettype wire

// ==== source/mbus_if.sv ====
//**************************************************
// internal memory bus, master and slave modports
//**************************************************

`timescale 1ns/1ps
`default_nettype none

interface mbus_if
    import pcomp_pkg::*;
();

    // request, one-cycle we or rd pulse
    addr_t a;
    word_t d;
    logic  we;
    logic  rd;

    // response
    word_t spo;
    logic  ready;
    logic  err;

    modport master (
        output a, d, we, rd,
        input  spo, ready, err
    );

    modport slave (
        input  a, d, we, rd,
        output spo, ready, err
    );

endinterface

`default_nettype wire

// ==== source/axil_bridge.sv ====
//**************************************************
// AXI4-Lite slave to internal bus bridge
// one transaction in flight, writes win a tie
//**************************************************

`timescale 1ns/1ps
`default_nettype none

module axil_bridge
    import pcomp_pkg::*;
(
    input  logic   clk_main,
    input  logic   reset,

    input  addr_t  awaddr,
    input  logic   awvalid,
    output logic   awready,
    input  word_t  wdata,
    input  logic   wvalid,
    output logic   wready,
    output resp_t  bresp,
    output logic   bvalid,
    input  logic   bready,

    input  addr_t  araddr,
    input  logic   arvalid,
    output logic   arready,
    output word_t  rdata,
    output resp_t  rresp,
    output logic   rvalid,
    input  logic   rready,

    mbus_if.master bus
);

    localparam resp_t resp_okay   = 2'b00;
    localparam resp_t resp_slverr = 2'b10;

    bridge_state_t state;
    bridge_state_t state_next;

    logic  write_go;
    logic  read_go;
    logic  write_q;
    addr_t addr_q;
    word_t wdata_q;
    word_t rdata_q;
    logic  err_q;

    // both write channels present, only in idle
    assign write_go = (state == idle) && awvalid && wvalid;
    assign read_go  = (state == idle) && arvalid && !(awvalid && wvalid);

    assign awready = write_go;
    assign wready  = write_go;
    assign arready = read_go;

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (write_go || read_go) begin
                    state_next = access;
                end
            end
            access, wait_ready: begin
                if (bus.ready) begin
                    state_next = write_q ? write_resp : read_resp;
                end else begin
                    state_next = wait_ready;
                end
            end
            write_resp: begin
                if (bready) begin
                    state_next = idle;
                end
            end
            read_resp: begin
                if (rready) begin
                    state_next = idle;
                end
            end
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk_main) begin
        if (reset) begin
            state   <= idle;
            write_q <= 1'b0;
        end else begin
            state <= state_next;
            if (write_go || read_go) begin
                write_q <= write_go;
            end
        end
    end

    // request latch and response capture
    always_ff @(posedge clk_main) begin
        if (write_go) begin
            addr_q  <= awaddr;
            wdata_q <= wdata;
        end else if (read_go) begin
            addr_q <= araddr;
        end
        if ((state == access || state == wait_ready) && bus.ready) begin
            rdata_q <= bus.spo;
            err_q   <= bus.err;
        end
    end

    assign bus.a  = addr_q;
    assign bus.d  = wdata_q;
    assign bus.we = (state == access) && write_q;
    assign bus.rd = (state == access) && !write_q;

    // response path, held until taken
    assign bvalid = (state == write_resp);
    assign rvalid = (state == read_resp);
    assign bresp  = err_q ? resp_slverr : resp_okay;
    assign rresp  = err_q ? resp_slverr : resp_okay;
    assign rdata  = rdata_q;

endmodule

`default_nettype wire

// ==== source/mmapper.sv ====
//**************************************************
// memory mapper: RAM and GPIO decode, response
// mux and unmapped access error
//**************************************************

`timescale 1ns/1ps
`default_nettype none

`include "pcomp_settings.svh"

module mmapper
    import pcomp_pkg::*;
(
    mbus_if.slave  cpu,
    mbus_if.master ram,
    mbus_if.master gpio
);

    logic sel_ram;
    logic sel_gpio;
    logic sel_none;
    logic pulse;

    assign sel_ram  = (cpu.a & ~`PCOMP_RAM_MASK) == `PCOMP_RAM_BASE;
    assign sel_gpio = (cpu.a & ~`PCOMP_GPIO_MASK) == `PCOMP_GPIO_BASE;
    assign sel_none = !sel_ram && !sel_gpio;
    assign pulse    = cpu.we || cpu.rd;

    // word index inside each window
    assign ram.a  = (cpu.a & `PCOMP_RAM_MASK) >> 2;
    assign ram.d  = cpu.d;
    assign ram.we = cpu.we && sel_ram;
    assign ram.rd = cpu.rd && sel_ram;

    assign gpio.a  = (cpu.a & `PCOMP_GPIO_MASK) >> 2;
    assign gpio.d  = cpu.d;
    assign gpio.we = cpu.we && sel_gpio;
    assign gpio.rd = cpu.rd && sel_gpio;

    always_comb begin
        if (sel_ram) begin
            cpu.spo   = ram.spo;
            cpu.ready = ram.ready;
        end else if (sel_gpio) begin
            cpu.spo   = gpio.spo;
            cpu.ready = gpio.ready;
        end else begin
            // nothing there, answer at once
            cpu.spo   = '0;
            cpu.ready = pulse;
        end
    end

    assign cpu.err = sel_none && pulse;

endmodule

`default_nettype wire

// ==== source/data_ram.sv ====
//**************************************************
// word RAM, registered read, ready one cycle
// after the access pulse
//**************************************************

`timescale 1ns/1ps
`default_nettype none

`include "pcomp_settings.svh"

module data_ram
    import pcomp_pkg::*;
(
    input  logic  clk_main,
    mbus_if.slave bus
);

    word_t mem [0:(1 << `PCOMP_RAM_DEPTH)-1];

    logic [`PCOMP_RAM_DEPTH-1:0] idx;
    word_t rdata_q;
    logic  ready_q;

    assign idx = bus.a[`PCOMP_RAM_DEPTH-1:0];

    always_ff @(posedge clk_main) begin
        if (bus.we) begin
            mem[idx] <= bus.d;
        end
        if (bus.rd) begin
            rdata_q <= mem[idx];
        end
    end

    // ack for reads and writes alike
    always_ff @(posedge clk_main) begin
        ready_q <= bus.we || bus.rd;
    end

    assign bus.spo   = rdata_q;
    assign bus.ready = ready_q;

endmodule

`default_nettype wire

// ==== source/gpio.sv ====
//**************************************************
// GPIO: LED register, button sampling and
// rising-edge interrupt with write-1-to-clear
//**************************************************

`timescale 1ns/1ps
`default_nettype none

`include "pcomp_settings.svh"

module gpio
    import pcomp_pkg::*;
(
    input  logic       clk_main,
    input  logic       reset,
    mbus_if.slave      bus,
    input  logic [1:0] btn,
    output logic [1:0] led,
    output logic       irq
);

    // word indices of the registers
    localparam logic [1:0] led_idx = 2'(`PCOMP_GPIO_LED >> 2);
    localparam logic [1:0] btn_idx = 2'(`PCOMP_GPIO_BTN >> 2);
    localparam logic [1:0] irq_idx = 2'(`PCOMP_GPIO_IRQ >> 2);

    logic [1:0] led_q;
    logic [1:0] btn_q;
    logic [1:0] btn_prev;
    logic [1:0] status_q;
    logic [1:0] rise;
    logic [1:0] clr;
    logic       hit_led;
    logic       hit_irq;

    assign hit_led = bus.we && (bus.a[1:0] == led_idx);
    assign hit_irq = bus.we && (bus.a[1:0] == irq_idx);
    assign clr     = hit_irq ? bus.d[1:0] : 2'b00;
    assign rise    = btn_q & ~btn_prev;

    always_ff @(posedge clk_main) begin
        if (reset) begin
            led_q    <= '0;
            btn_q    <= '0;
            btn_prev <= '0;
            status_q <= '0;
        end else begin
            btn_q    <= btn;
            btn_prev <= btn_q;
            if (hit_led) begin
                led_q <= bus.d[1:0];
            end
            // a new edge beats the clear
            status_q <= (status_q & ~clr) | rise;
        end
    end

    always_comb begin
        case (bus.a[1:0])
            led_idx: bus.spo = word_t'(led_q);
            btn_idx: bus.spo = word_t'(btn_q);
            irq_idx: bus.spo = word_t'(status_q);
            default: bus.spo = '0;
        endcase
    end

    // registers answer in the same cycle
    assign bus.ready = bus.we || bus.rd;

    assign led = led_q;
    assign irq = |status_q;

endmodule

`default_nettype wire

// ==== source/pcomp_top.sv ====
//**************************************************
// SoC memory-mapped block: AXI4-Lite bridge,
// mapper, word RAM and GPIO
//**************************************************

`timescale 1ns/1ps
`default_nettype none

module pcomp_top
    import pcomp_pkg::*;
(
    input  logic       clk_main,
    input  logic       reset,

    input  addr_t      awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  word_t      wdata,
    input  logic       wvalid,
    output logic       wready,
    output resp_t      bresp,
    output logic       bvalid,
    input  logic       bready,

    input  addr_t      araddr,
    input  logic       arvalid,
    output logic       arready,
    output word_t      rdata,
    output resp_t      rresp,
    output logic       rvalid,
    input  logic       rready,

    input  logic [1:0] btn,
    output logic [1:0] led,
    output logic       irq
);

    mbus_if cpu_bus ();
    mbus_if ram_bus ();
    mbus_if gpio_bus ();

    axil_bridge i_axil_bridge (
        .clk_main (clk_main),
        .reset    (reset),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .bus      (cpu_bus.master)
    );

    mmapper i_mmapper (
        .cpu  (cpu_bus.slave),
        .ram  (ram_bus.master),
        .gpio (gpio_bus.master)
    );

    data_ram i_data_ram (
        .clk_main (clk_main),
        .bus      (ram_bus.slave)
    );

    gpio i_gpio (
        .clk_main (clk_main),
        .reset    (reset),
        .bus      (gpio_bus.slave),
        .btn      (btn),
        .led      (led),
        .irq      (irq)
    );

endmodule

`default_nettype wire

// ==== bench/pcomp_chk.sv ====
//**************************************************
// bound assertions on AXI response hold, bus pulse
// width and one outstanding bus access
//**************************************************

`timescale 1ns/1ps
`default_nettype none

module pcomp_chk
    import pcomp_pkg::*;
(
    input logic  clk_main,
    input logic  reset,
    input logic  bvalid,
    input logic  bready,
    input resp_t bresp,
    input logic  rvalid,
    input logic  rready,
    input resp_t rresp,
    input word_t rdata,
    input logic  bus_we,
    input logic  bus_rd,
    input logic  bus_ready
);

    logic pulse;
    logic pending;

    // number of failed assertions
    int   fail_count = 0;

    assign pulse = bus_we || bus_rd;

    // access issued and ready not yet seen
    always_ff @(posedge clk_main) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (pulse && !bus_ready) begin
            pending <= 1'b1;
        end else if (bus_ready) begin
            pending <= 1'b0;
        end
    end

    a_bvalid_hold: assert property (@(posedge clk_main) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            fail_count++;
            $error("bvalid or bresp changed before bready");
        end

    a_rvalid_hold: assert property (@(posedge clk_main) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata))
        else begin
            fail_count++;
            $error("rvalid, rresp or rdata changed before rready");
        end

    a_we_pulse: assert property (@(posedge clk_main) disable iff (reset)
        bus_we |=> !bus_we)
        else begin
            fail_count++;
            $error("bus write pulse longer than one cycle");
        end

    a_rd_pulse: assert property (@(posedge clk_main) disable iff (reset)
        bus_rd |=> !bus_rd)
        else begin
            fail_count++;
            $error("bus read pulse longer than one cycle");
        end

    a_one_outstanding: assert property (@(posedge clk_main) disable iff (reset)
        pulse |-> !pending)
        else begin
            fail_count++;
            $error("bus access issued while another is outstanding");
        end

endmodule

bind axil_bridge pcomp_chk i_pcomp_chk (
    .clk_main  (clk_main),
    .reset     (reset),
    .bvalid    (bvalid),
    .bready    (bready),
    .bresp     (bresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .rresp     (rresp),
    .rdata     (rdata),
    .bus_we    (bus.we),
    .bus_rd    (bus.rd),
    .bus_ready (bus.ready)
);

`default_nettype wire

// ==== bench/tb_pcomp.sv ====
//**************************************************
// testbench with AXI4-Lite tasks, reference model,
// response compare, watchdog and verdict
//**************************************************

`timescale 1ns/1ps
`default_nettype none

`include "pcomp_settings.svh"

module tb_pcomp
    import pcomp_pkg::*;
();

    localparam int n_ram_writes = 40;
    localparam int n_ram_reads  = 30;
    localparam int n_trans      = n_ram_writes + n_ram_reads + 50;

    logic clk_main;
    logic reset;
    addr_t awaddr;
    addr_t araddr;
    word_t wdata;
    word_t rdata;
    resp_t bresp;
    resp_t rresp;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready, irq;
    logic [1:0] btn;
    logic [1:0] led;

    // reference state
    word_t ram_model [addr_t];
    logic [1:0] led_model;
    logic [1:0] btn_model;
    logic [1:0] irq_model;

    logic [33:0] exp_q [$];
    logic [33:0] act_q [$];
    int num_issued = 0;
    int num_compared = 0;
    int assert_fails;

    pcomp_top i_pcomp_top (.*);

    assign assert_fails = i_pcomp_top.i_axil_bridge.i_pcomp_chk.fail_count;

    initial begin
        clk_main = 1'b0;
        forever #20 clk_main = ~clk_main;
    end

    task automatic check(input string what, input logic [33:0] got, input logic [33:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1, "check failed");
        end
    endtask

    // returns the expected {resp, rdata} and updates the model on writes
    function automatic logic [33:0] ref_access(input logic is_write, input addr_t addr,
                                               input word_t data);
        word_t rd_val;
        resp_t resp;
        rd_val = '0;
        resp = 2'b00;
        if (addr < `PCOMP_RAM_BASE + 32'h4000) begin
            if (is_write) begin
                ram_model[addr >> 2] = data;
            end
            rd_val = ram_model[addr >> 2];
        end else if (addr >= `PCOMP_GPIO_BASE && addr < `PCOMP_GPIO_BASE + 32'h10) begin
            case (addr[3:0])
                4'h0: rd_val = {30'h0, led_model};
                4'h4: rd_val = {30'h0, btn_model};
                4'h8: rd_val = {30'h0, irq_model};
                default: rd_val = '0;
            endcase
            if (is_write && addr[3:0] == 4'h0) begin
                led_model = data[1:0];
            end
            if (is_write && addr[3:0] == 4'h8) begin
                irq_model = irq_model & ~data[1:0];
            end
        end else begin
            resp = 2'b10;
        end
        return is_write ? {resp, 32'h0} : {resp, rd_val};
    endfunction

    task automatic axi_write(input addr_t addr, input word_t data, input int hold);
        resp_t first_resp;
        exp_q.push_back(ref_access(1'b1, addr, data));
        num_issued++;
        @(negedge clk_main);
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        @(posedge clk_main);
        while (!(awready && wready)) begin
            @(posedge clk_main);
        end
        @(negedge clk_main);
        awvalid = 1'b0;
        wvalid = 1'b0;
        while (!bvalid) begin
            @(negedge clk_main);
        end
        first_resp = bresp;
        repeat (hold) begin
            @(negedge clk_main);
            check("bvalid under back-pressure", {33'h0, bvalid}, 34'h1);
            check("bresp under back-pressure", {32'h0, bresp}, {32'h0, first_resp});
        end
        act_q.push_back({bresp, 32'h0});
        bready = 1'b1;
        @(negedge clk_main);
        bready = 1'b0;
    endtask

    task automatic axi_read(input addr_t addr, input int hold);
        logic [33:0] first;
        exp_q.push_back(ref_access(1'b0, addr, '0));
        num_issued++;
        @(negedge clk_main);
        araddr = addr;
        arvalid = 1'b1;
        @(posedge clk_main);
        while (!arready) begin
            @(posedge clk_main);
        end
        @(negedge clk_main);
        arvalid = 1'b0;
        while (!rvalid) begin
            @(negedge clk_main);
        end
        first = {rresp, rdata};
        repeat (hold) begin
            @(negedge clk_main);
            check("rvalid under back-pressure", {33'h0, rvalid}, 34'h1);
            check("rresp and rdata under back-pressure", {rresp, rdata}, first);
        end
        act_q.push_back({rresp, rdata});
        rready = 1'b1;
        @(negedge clk_main);
        rready = 1'b0;
    endtask

    // rising bits set the status and the sync stages get three cycles
    task automatic set_buttons(input logic [1:0] val);
        irq_model = irq_model | (val & ~btn_model);
        btn_model = val;
        @(negedge clk_main);
        btn = val;
        repeat (3) @(negedge clk_main);
        check("irq pin after button change", {33'h0, irq}, {33'h0, |irq_model});
    endtask

    initial begin
        forever begin
            @(negedge clk_main);
            while (act_q.size() > 0 && exp_q.size() > 0) begin
                check($sformatf("response %0d", num_compared), act_q.pop_front(),
                      exp_q.pop_front());
                num_compared++;
            end
        end
    end

    // bound checker failures end the run at the next falling edge
    initial begin
        forever begin
            @(negedge clk_main);
            if (assert_fails != 0) begin
                $display("Assertion failed in the bound bridge checker at %0t ns", $time);
                $display("Verification failed");
                $fatal(1, "assertion failed");
            end
        end
    end

    initial begin
        repeat (n_trans * 200) @(posedge clk_main);
        $display("Timeout: the bus hung, no end of test after %0d cycles", n_trans * 200);
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        addr_t written [$];
        addr_t addr;
        int pick;
        void'($urandom(32'h12fd_a5e7));
        reset = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        btn = 2'b00;
        led_model = 2'b00;
        btn_model = 2'b00;
        irq_model = 2'b00;
        repeat (5) @(negedge clk_main);
        reset = 1'b0;

        // few distinct RAM words so some get overwritten
        for (int i = 0; i < n_ram_writes; i++) begin
            pick = $urandom_range(0, 23);
            addr = 32'(pick * 684);
            axi_write(addr, $urandom, 0);
            written.push_back(addr);
        end
        for (int i = 0; i < n_ram_reads; i++) begin
            axi_read(written[$urandom_range(0, written.size() - 1)], 0);
        end

        for (int i = 0; i < 4; i++) begin
            axi_write(`PCOMP_GPIO_BASE + `PCOMP_GPIO_LED, $urandom, 0);
            check("led pin", {32'h0, led}, {32'h0, led_model});
            axi_read(`PCOMP_GPIO_BASE + `PCOMP_GPIO_LED, 0);
        end

        set_buttons(2'b01);
        axi_read(`PCOMP_GPIO_BASE + `PCOMP_GPIO_BTN, 0);
        axi_read(`PCOMP_GPIO_BASE + `PCOMP_GPIO_IRQ, 0);
        axi_write(`PCOMP_GPIO_BASE + `PCOMP_GPIO_IRQ, 32'h1, 0);
        check("irq pin after clear", {33'h0, irq}, {33'h0, |irq_model});
        set_buttons(2'b11);
        axi_read(`PCOMP_GPIO_BASE + `PCOMP_GPIO_BTN, 0);
        axi_read(`PCOMP_GPIO_BASE + `PCOMP_GPIO_IRQ, 0);
        axi_write(`PCOMP_GPIO_BASE + `PCOMP_GPIO_IRQ, 32'h2, 0);
        check("irq pin after clear", {33'h0, irq}, {33'h0, |irq_model});
        set_buttons(2'b00);
        set_buttons(2'b10);
        axi_read(`PCOMP_GPIO_BASE + `PCOMP_GPIO_IRQ, 0);
        axi_write(`PCOMP_GPIO_BASE + `PCOMP_GPIO_IRQ, 32'h3, 0);
        check("irq pin after clear", {33'h0, irq}, {33'h0, |irq_model});

        // addresses outside both windows and an empty GPIO slot
        axi_write(32'h4000_0000, $urandom, 0);
        axi_read(32'h4000_0000, 0);
        axi_read(32'h0000_4000, 0);
        axi_write(32'h9000_0010, $urandom, 0);
        axi_read(`PCOMP_GPIO_BASE + 32'hc, 0);

        for (int i = 0; i < 12; i++) begin
            if (i % 3 == 0) begin
                axi_write(written[$urandom_range(0, written.size() - 1)], $urandom,
                          $urandom_range(1, 6));
            end else begin
                axi_read(written[$urandom_range(0, written.size() - 1)], $urandom_range(1, 6));
            end
        end
        axi_read(32'h8000_0000, 4);
        axi_read(`PCOMP_GPIO_BASE + `PCOMP_GPIO_LED, 5);

        repeat (2) @(negedge clk_main);
        if (num_compared == num_issued && act_q.size() == 0 && assert_fails == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Only %0d of %0d responses were compared, %0d assertion failures",
                     num_compared, num_issued, assert_fails);
            $display("Verification failed");
            $fatal(1, "run incomplete");
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+source
source/pcomp_pkg.sv
source/mbus_if.sv
source/axil_bridge.sv
source/mmapper.sv
source/data_ram.sv
source/gpio.sv
source/pcomp_top.sv
bench/pcomp_chk.sv
bench/tb_pcomp.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the pcomp testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_pcomp -Mdir obj_dir -f tb.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed, status $status"
    exit 1
fi

./obj_dir/Vtb_pcomp
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed, status $status"
    exit 1
fi

echo "simulation finished cleanly"
exit 0
